// File: common/issue_consts.svh
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

// Datapath and PC width
`define ISSUE_WORD_W 16

// Register file index width
`define ISSUE_REG_W 3

// ROB entry / tag width
`define ISSUE_ROB_W 3

// ALU reservation stations
`define ISSUE_ALU_RS 3

// Width of res_station_id
`define ISSUE_RS_ID_W 3

`endif

// File: common/lc3b_pkg.sv
`default_nettype none

package lc3b_pkg;

	`include "issue_consts.svh"

	typedef logic [`ISSUE_WORD_W-1:0] lc3b_word;
	typedef logic [`ISSUE_REG_W-1:0] lc3b_reg;
	typedef logic [`ISSUE_ROB_W-1:0] lc3b_rob_addr;

	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	// Register form, ALU ops and the base+offset6 memory ops
	typedef struct packed {
		lc3b_opcode op;
		lc3b_reg    dr;
		lc3b_reg    sr1;
		logic       imm_flag; // bit 5
		logic [4:0] imm5_sr2;
	} lc3b_instr_reg_t;

	// PC-relative form, BR and LEA
	typedef struct packed {
		lc3b_opcode op;
		lc3b_reg    dr;
		logic [8:0] off9;
	} lc3b_instr_off_t;

	typedef union packed {
		lc3b_instr_reg_t r;
		lc3b_instr_off_t o;
	} lc3b_instr_u;

endpackage

`default_nettype wire

// File: rtl/operand_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module operand_resolve
	import lc3b_pkg::*;
(
	// Register file view of the operand
	input  logic         reg_busy,
	input  lc3b_word     reg_data,
	input  lc3b_rob_addr reg_rob_entry,
	// Broadcast result this cycle
	input  logic         cdb_valid,
	input  lc3b_rob_addr cdb_tag,
	input  lc3b_word     cdb_data,
	// ROB read port for the producing entry
	input  logic         rob_valid,
	input  lc3b_word     rob_value,
	output logic         ready,
	output lc3b_word     value,
	output lc3b_rob_addr tag
);

	logic cdb_hit;

	assign cdb_hit = cdb_valid && (cdb_tag == reg_rob_entry);

	// Regfile first, then CDB, then ROB, else wait on the tag
	always_comb
	begin
		ready = 1'b1;
		value = '0;
		tag   = '0;
		if (!reg_busy)
			value = reg_data;
		else if (cdb_hit)
			value = cdb_data;     // Producer finishing right now
		else if (rob_valid)
			value = rob_value;    // Done but not yet committed
		else
		begin
			ready = 1'b0;
			tag   = reg_rob_entry;
		end
	end

endmodule

`default_nettype wire

// File: issue/issue_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "issue_consts.svh"

module issue_decode
	import lc3b_pkg::*;
(
	input  lc3b_instr_u  instr,
	input  logic         instr_is_new,
	input  lc3b_word     curr_pc,
	input  logic         rob_full,
	input  lc3b_rob_addr rob_addr,
	input  logic [`ISSUE_ALU_RS-1:0] alu_rs_busy,
	input  logic         ldstr_full,
	input  logic         predict_bit,
	// Resolved operands
	input  logic         base_ready,
	input  lc3b_word     base_value,
	input  lc3b_rob_addr base_tag,
	input  logic         sr2_ready,
	input  lc3b_word     sr2_value,
	input  lc3b_rob_addr sr2_tag,
	input  logic         src_ready,
	input  lc3b_word     src_value,
	input  lc3b_rob_addr src_tag,
	input  lc3b_rob_addr sr2_rob_entry,
	input  lc3b_rob_addr dest_rob_entry,
	// Sequencer state
	input  logic         ldi_second,
	input  lc3b_rob_addr ldi_rob_e,
	input  logic         branch_shadow,
	input  logic         cdb_valid,
	input  lc3b_rob_addr cdb_tag,
	input  lc3b_word     cdb_data,
	// Fetch
	output logic         stall,
	output logic         pcmux_sel,
	output lc3b_word     br_pc,
	// Reservation stations
	output lc3b_opcode   res_op_in,
	output lc3b_word     res_vj,
	output lc3b_word     res_vk,
	output lc3b_rob_addr res_qj,
	output lc3b_rob_addr res_qk,
	output lc3b_rob_addr res_dest,
	output logic         issue_ld_busy_dest,
	output logic         issue_ld_vj,
	output logic         issue_ld_vk,
	output logic         issue_ld_qj,
	output logic         issue_ld_qk,
	output logic [`ISSUE_RS_ID_W-1:0] res_station_id,
	// Load/store buffer
	output logic         ldstr_write_enable,
	output lc3b_word     ldstr_offset,
	output lc3b_rob_addr ldstr_qsrc,
	output lc3b_rob_addr ldstr_qbase,
	output lc3b_rob_addr ldstr_dest,
	output logic         ldstr_vsrc_valid,
	output logic         ldstr_vbase_valid,
	output lc3b_word     ldstr_vsrc,
	output lc3b_word     ldstr_vbase,
	// ROB
	output logic         rob_write_enable,
	output lc3b_opcode   rob_opcode,
	output lc3b_reg      rob_dest,
	output lc3b_word     rob_value_in,
	output lc3b_rob_addr rob_sr2_read_addr,
	// Register file
	output lc3b_reg      reg_dest,
	output logic         ld_reg_busy_dest,
	output lc3b_rob_addr reg_rob_entry,
	// Sequencer
	output logic         ldi_first_issue,
	output logic         ldi_second_done,
	output logic         br_taken_issue
);

	lc3b_opcode opcode;
	lc3b_reg    dr;
	lc3b_word   sext5;
	lc3b_word   sext6;
	lc3b_word   adj6;
	lc3b_word   adj9;
	logic [5:0] off6;
	logic       is_alu;
	logic       is_mem;
	logic       is_store;
	logic       blocked;
	logic       go;
	logic       ldi_hit;

	assign opcode = instr.r.op;
	assign dr     = instr.r.dr;
	assign off6   = {instr.r.imm_flag, instr.r.imm5_sr2};

	assign sext5 = {{(`ISSUE_WORD_W-5){instr.r.imm5_sr2[4]}}, instr.r.imm5_sr2};
	assign sext6 = {{(`ISSUE_WORD_W-6){off6[5]}}, off6};
	assign adj6  = {{(`ISSUE_WORD_W-7){off6[5]}}, off6, 1'b0};
	assign adj9  = {{(`ISSUE_WORD_W-10){instr.o.off9[8]}}, instr.o.off9, 1'b0};

	assign is_alu   = (opcode == op_add) || (opcode == op_and) ||
	                  (opcode == op_not) || (opcode == op_shf);
	assign is_store = (opcode == op_str) || (opcode == op_stb);
	assign is_mem   = is_store || (opcode == op_ldr) || (opcode == op_ldb) ||
	                  (opcode == op_ldi);

	assign blocked = rob_full || (is_alu && (&alu_rs_busy)) || (is_mem && ldstr_full);
	assign go      = instr_is_new && !branch_shadow && !blocked;

	// First LDI step holds fetch so the same word comes back
	assign stall = instr_is_new && !branch_shadow &&
	               (blocked || ((opcode == op_ldi) && !ldi_second));

	assign ldi_first_issue = go && (opcode == op_ldi) && !ldi_second;
	assign ldi_second_done = go && (opcode == op_ldi) && ldi_second;
	assign br_taken_issue  = go && (opcode == op_br) && predict_bit;
	assign pcmux_sel       = br_taken_issue;

	assign br_pc             = curr_pc + adj9;
	assign rob_opcode        = opcode;
	assign res_dest          = rob_addr;
	assign rob_sr2_read_addr = is_store ? dest_rob_entry : sr2_rob_entry;
	assign ldi_hit           = cdb_valid && (cdb_tag == ldi_rob_e);

	// Lowest free station wins
	always_comb
	begin
		res_station_id = '0;
		for (int i = `ISSUE_ALU_RS - 1; i >= 0; i--)
			if (!alu_rs_busy[i])
				res_station_id = `ISSUE_RS_ID_W'(i);
	end

	always_comb
	begin
		res_op_in          = op_br;
		res_vj             = '0;
		res_vk             = '0;
		res_qj             = '0;
		res_qk             = '0;
		issue_ld_busy_dest = 1'b0;
		issue_ld_vj        = 1'b0;
		issue_ld_vk        = 1'b0;
		issue_ld_qj        = 1'b0;
		issue_ld_qk        = 1'b0;
		ldstr_write_enable = 1'b0;
		ldstr_offset       = '0;
		ldstr_qsrc         = '0;
		ldstr_qbase        = '0;
		ldstr_dest         = rob_addr;
		ldstr_vsrc_valid   = 1'b0;
		ldstr_vbase_valid  = 1'b0;
		ldstr_vsrc         = '0;
		ldstr_vbase        = '0;
		rob_write_enable   = 1'b0;
		rob_dest           = '0;
		rob_value_in       = '0;
		reg_dest           = '0;
		ld_reg_busy_dest   = 1'b0;
		reg_rob_entry      = '0;

		if (go)
		begin
			case (opcode)
				op_add, op_and, op_not, op_shf:
				begin
					res_op_in          = opcode;
					issue_ld_busy_dest = 1'b1;
					res_vj      = base_value;
					res_qj      = base_tag;
					issue_ld_vj = base_ready;
					issue_ld_qj = !base_ready;
					if (instr.r.imm_flag || (opcode == op_shf))
					begin
						res_vk      = sext5;   // Immediate or shift amount
						issue_ld_vk = 1'b1;
					end
					else
					begin
						res_vk      = sr2_value;
						res_qk      = sr2_tag;
						issue_ld_vk = sr2_ready;
						issue_ld_qk = !sr2_ready;
					end
					rob_write_enable = 1'b1;
					rob_dest         = dr;
					reg_dest         = dr;
					ld_reg_busy_dest = 1'b1;
					reg_rob_entry    = rob_addr;
				end

				op_ldr, op_ldb, op_str, op_stb:
				begin
					ldstr_write_enable = 1'b1;
					res_op_in          = opcode;
					ldstr_offset       = ((opcode == op_ldb) || (opcode == op_stb)) ? sext6 : adj6;
					ldstr_vbase        = base_value;
					ldstr_qbase        = base_tag;
					ldstr_vbase_valid  = base_ready;
					rob_write_enable   = 1'b1;
					reg_dest           = dr;
					if (is_store)
					begin
						ldstr_dest       = '0;    // Stores produce no register result
						ldstr_vsrc       = src_value;
						ldstr_qsrc       = src_tag;
						ldstr_vsrc_valid = src_ready;
					end
					else
					begin
						rob_dest         = dr;
						ld_reg_busy_dest = 1'b1;
						reg_rob_entry    = rob_addr;
					end
				end

				op_br:
				begin
					rob_write_enable = 1'b1;
					rob_dest         = dr;
					// Keep the fall-through PC for recovery if predicted taken
					rob_value_in     = predict_bit ? curr_pc : br_pc;
				end

				op_lea:
				begin
					rob_write_enable = 1'b1;
					rob_value_in     = br_pc;  // Same PC-relative sum as BR
					rob_dest         = dr;
					reg_dest         = dr;
					ld_reg_busy_dest = 1'b1;
					reg_rob_entry    = rob_addr;
				end

				op_ldi:
				begin
					ldstr_write_enable = 1'b1;
					res_op_in          = op_ldr;
					rob_write_enable   = 1'b1;
					rob_dest           = dr;
					if (!ldi_second)
					begin
						// Pointer fetch
						ldstr_vbase       = base_value;
						ldstr_qbase       = base_tag;
						ldstr_vbase_valid = base_ready;
					end
					else
					begin
						ldstr_offset = adj6;
						if (ldi_hit)
						begin
							ldstr_vbase       = cdb_data;
							ldstr_vbase_valid = 1'b1;
						end
						else
							ldstr_qbase = ldi_rob_e;  // Wait on the pointer load
						reg_dest         = dr;
						ld_reg_busy_dest = 1'b1;
						reg_rob_entry    = rob_addr;
					end
				end

				default:;  // Not handled at this stage
			endcase
		end
	end

endmodule

`default_nettype wire

// File: issue/issue_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module issue_sequencer
	import lc3b_pkg::*;
(
	input  logic         clk,
	input  logic         arst_n,
	input  logic         ldi_first_issue,
	input  logic         ldi_second_done,
	input  logic         br_taken_issue,
	input  lc3b_rob_addr rob_addr,
	output logic         ldi_second,
	output lc3b_rob_addr ldi_rob_e,
	output logic         branch_shadow
);

	// LDI phase and the ROB entry of the pointer load
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ldi_second <= 1'b0;
			ldi_rob_e  <= '0;
		end
		else if (ldi_first_issue)
		begin
			ldi_second <= 1'b1;
			ldi_rob_e  <= rob_addr;  // Entry just written by the first step
		end
		else if (ldi_second_done)
		begin
			ldi_second <= 1'b0;
			ldi_rob_e  <= '0;
		end
	end

	// One cycle to drop the wrong-path word after a taken redirect
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			branch_shadow <= 1'b0;
		else
			branch_shadow <= br_taken_issue;
	end

endmodule

`default_nettype wire

// File: issue/issue_control.sv
`timescale 1ns/1ps
`default_nettype none
`include "issue_consts.svh"

module issue_control
	import lc3b_pkg::*;
(
	input  logic         clk,
	input  logic         arst_n,
	// Fetch
	input  lc3b_word     instr,
	input  lc3b_word     curr_pc,
	input  logic         instr_is_new,
	// Register file
	input  logic         sr1_busy,
	input  lc3b_word     sr1_data,
	input  lc3b_rob_addr sr1_rob_entry,
	input  logic         sr2_busy,
	input  lc3b_word     sr2_data,
	input  lc3b_rob_addr sr2_rob_entry,
	input  logic         dest_busy,
	input  lc3b_word     dest_data,
	input  lc3b_rob_addr dest_rob_entry,
	// CDB
	input  logic         cdb_valid,
	input  lc3b_rob_addr cdb_tag,
	input  lc3b_word     cdb_data,
	// ROB
	input  logic         rob_full,
	input  lc3b_rob_addr rob_addr,
	input  lc3b_word     rob_sr1_value,
	input  logic         rob_sr1_valid,
	input  lc3b_word     rob_sr2_value,
	input  logic         rob_sr2_valid,
	// Stations, buffer and predictor
	input  logic [`ISSUE_ALU_RS-1:0] alu_rs_busy,
	input  logic         ldstr_full,
	input  logic         predict_bit,
	output logic         stall,
	output logic         pcmux_sel,
	output lc3b_word     br_pc,
	output lc3b_opcode   res_op_in,
	output lc3b_word     res_vj,
	output lc3b_word     res_vk,
	output lc3b_rob_addr res_qj,
	output lc3b_rob_addr res_qk,
	output lc3b_rob_addr res_dest,
	output logic         issue_ld_busy_dest,
	output logic         issue_ld_vj,
	output logic         issue_ld_vk,
	output logic         issue_ld_qj,
	output logic         issue_ld_qk,
	output logic [`ISSUE_RS_ID_W-1:0] res_station_id,
	output logic         ldstr_write_enable,
	output lc3b_word     ldstr_offset,
	output lc3b_rob_addr ldstr_qsrc,
	output lc3b_rob_addr ldstr_qbase,
	output lc3b_rob_addr ldstr_dest,
	output logic         ldstr_vsrc_valid,
	output logic         ldstr_vbase_valid,
	output lc3b_word     ldstr_vsrc,
	output lc3b_word     ldstr_vbase,
	output logic         rob_write_enable,
	output lc3b_opcode   rob_opcode,
	output lc3b_reg      rob_dest,
	output lc3b_word     rob_value_in,
	output lc3b_rob_addr rob_sr2_read_addr,
	output lc3b_reg      reg_dest,
	output logic         ld_reg_busy_dest,
	output lc3b_rob_addr reg_rob_entry
);

	logic         base_ready, sr2_ready, src_ready;
	lc3b_word     base_value, sr2_value, src_value;
	lc3b_rob_addr base_tag, sr2_tag, src_tag;
	logic         ldi_second, branch_shadow;
	lc3b_rob_addr ldi_rob_e;
	logic         ldi_first_issue, ldi_second_done, br_taken_issue;

	// Base / sr1 operand on ROB port 1
	operand_resolve u_base_op (
		.reg_busy(sr1_busy), .reg_data(sr1_data), .reg_rob_entry(sr1_rob_entry),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
		.rob_valid(rob_sr1_valid), .rob_value(rob_sr1_value),
		.ready(base_ready), .value(base_value), .tag(base_tag)
	);

	operand_resolve u_sr2_op (
		.reg_busy(sr2_busy), .reg_data(sr2_data), .reg_rob_entry(sr2_rob_entry),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
		.rob_valid(rob_sr2_valid), .rob_value(rob_sr2_value),
		.ready(sr2_ready), .value(sr2_value), .tag(sr2_tag)
	);

	// Store source shares ROB port 2, readdressed for stores
	operand_resolve u_src_op (
		.reg_busy(dest_busy), .reg_data(dest_data), .reg_rob_entry(dest_rob_entry),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
		.rob_valid(rob_sr2_valid), .rob_value(rob_sr2_value),
		.ready(src_ready), .value(src_value), .tag(src_tag)
	);

	issue_decode u_decode (
		.instr(instr), .instr_is_new(instr_is_new), .curr_pc(curr_pc),
		.rob_full(rob_full), .rob_addr(rob_addr), .alu_rs_busy(alu_rs_busy),
		.ldstr_full(ldstr_full), .predict_bit(predict_bit),
		.base_ready(base_ready), .base_value(base_value), .base_tag(base_tag),
		.sr2_ready(sr2_ready), .sr2_value(sr2_value), .sr2_tag(sr2_tag),
		.src_ready(src_ready), .src_value(src_value), .src_tag(src_tag),
		.sr2_rob_entry(sr2_rob_entry), .dest_rob_entry(dest_rob_entry),
		.ldi_second(ldi_second), .ldi_rob_e(ldi_rob_e), .branch_shadow(branch_shadow),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
		.stall(stall), .pcmux_sel(pcmux_sel), .br_pc(br_pc),
		.res_op_in(res_op_in), .res_vj(res_vj), .res_vk(res_vk),
		.res_qj(res_qj), .res_qk(res_qk), .res_dest(res_dest),
		.issue_ld_busy_dest(issue_ld_busy_dest), .issue_ld_vj(issue_ld_vj),
		.issue_ld_vk(issue_ld_vk), .issue_ld_qj(issue_ld_qj), .issue_ld_qk(issue_ld_qk),
		.res_station_id(res_station_id),
		.ldstr_write_enable(ldstr_write_enable), .ldstr_offset(ldstr_offset),
		.ldstr_qsrc(ldstr_qsrc), .ldstr_qbase(ldstr_qbase), .ldstr_dest(ldstr_dest),
		.ldstr_vsrc_valid(ldstr_vsrc_valid), .ldstr_vbase_valid(ldstr_vbase_valid),
		.ldstr_vsrc(ldstr_vsrc), .ldstr_vbase(ldstr_vbase),
		.rob_write_enable(rob_write_enable), .rob_opcode(rob_opcode),
		.rob_dest(rob_dest), .rob_value_in(rob_value_in),
		.rob_sr2_read_addr(rob_sr2_read_addr),
		.reg_dest(reg_dest), .ld_reg_busy_dest(ld_reg_busy_dest),
		.reg_rob_entry(reg_rob_entry),
		.ldi_first_issue(ldi_first_issue), .ldi_second_done(ldi_second_done),
		.br_taken_issue(br_taken_issue)
	);

	issue_sequencer u_seq (
		.clk(clk), .arst_n(arst_n),
		.ldi_first_issue(ldi_first_issue), .ldi_second_done(ldi_second_done),
		.br_taken_issue(br_taken_issue), .rob_addr(rob_addr),
		.ldi_second(ldi_second), .ldi_rob_e(ldi_rob_e), .branch_shadow(branch_shadow)
	);

endmodule

`default_nettype wire

// File: tb/tb_issue_control.sv
`timescale 1ns/1ps
`default_nettype none
`include "issue_consts.svh"

module tb_issue_control
	import lc3b_pkg::*;
();

	localparam int alu_iters   = 40;
	localparam int mem_iters   = 40;
	localparam int test_cycles = 5 + alu_iters + mem_iters + 30;

	logic         clk;
	logic         arst_n;
	lc3b_word     instr;
	lc3b_word     curr_pc;
	logic         instr_is_new;
	logic         sr1_busy;
	lc3b_word     sr1_data;
	lc3b_rob_addr sr1_rob_entry;
	logic         sr2_busy;
	lc3b_word     sr2_data;
	lc3b_rob_addr sr2_rob_entry;
	logic         dest_busy;
	lc3b_word     dest_data;
	lc3b_rob_addr dest_rob_entry;
	logic         cdb_valid;
	lc3b_rob_addr cdb_tag;
	lc3b_word     cdb_data;
	logic         rob_full;
	lc3b_rob_addr rob_addr;
	lc3b_word     rob_sr1_value;
	logic         rob_sr1_valid;
	lc3b_word     rob_sr2_value;
	logic         rob_sr2_valid;
	logic [`ISSUE_ALU_RS-1:0] alu_rs_busy;
	logic         ldstr_full;
	logic         predict_bit;

	logic         stall;
	logic         pcmux_sel;
	lc3b_word     br_pc;
	lc3b_opcode   res_op_in;
	lc3b_word     res_vj;
	lc3b_word     res_vk;
	lc3b_rob_addr res_qj;
	lc3b_rob_addr res_qk;
	lc3b_rob_addr res_dest;
	logic         issue_ld_busy_dest;
	logic         issue_ld_vj;
	logic         issue_ld_vk;
	logic         issue_ld_qj;
	logic         issue_ld_qk;
	logic [`ISSUE_RS_ID_W-1:0] res_station_id;
	logic         ldstr_write_enable;
	lc3b_word     ldstr_offset;
	lc3b_rob_addr ldstr_qsrc;
	lc3b_rob_addr ldstr_qbase;
	lc3b_rob_addr ldstr_dest;
	logic         ldstr_vsrc_valid;
	logic         ldstr_vbase_valid;
	lc3b_word     ldstr_vsrc;
	lc3b_word     ldstr_vbase;
	logic         rob_write_enable;
	lc3b_opcode   rob_opcode;
	lc3b_reg      rob_dest;
	lc3b_word     rob_value_in;
	lc3b_rob_addr rob_sr2_read_addr;
	lc3b_reg      reg_dest;
	logic         ld_reg_busy_dest;
	lc3b_rob_addr reg_rob_entry;

	integer seed = 32'hfbd1_57a9;
	string  test_name = "reset";

	issue_control u_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic fail_stop();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_eq(input string what, input logic [15:0] exp, input logic [15:0] act);
		assert (act === exp)
		else
		begin
			$display("[FAIL] %s: %s expected %h, actual %h", test_name, what, exp, act);
			fail_stop();
		end
	endtask

	// Sign-extend the low bits of a field to a word
	function automatic lc3b_word sext(input logic [8:0] field, input int bits);
		lc3b_word w;
		for (int i = 0; i < 16; i++)
			w[i] = (i < bits) ? field[i] : field[bits-1];
		return w;
	endfunction

	// Packed as {ready, tag, value}
	function automatic logic [19:0] expect_operand(input logic busy, input lc3b_word data,
		input lc3b_rob_addr entry, input logic rob_valid, input lc3b_word rob_value);
		if (!busy)
			return {1'b1, 3'b000, data};
		if (cdb_valid && (cdb_tag == entry))
			return {1'b1, 3'b000, cdb_data};
		if (rob_valid)
			return {1'b1, 3'b000, rob_value};
		return {1'b0, entry, 16'h0000};
	endfunction

	function automatic logic [2:0] lowest_free(input logic [2:0] busy);
		if (!busy[0])
			return 3'd0;
		if (!busy[1])
			return 3'd1;
		return 3'd2;
	endfunction

	task automatic set_idle();
		instr          = '0;
		curr_pc        = '0;
		instr_is_new   = 1'b0;
		sr1_busy       = 1'b0;
		sr1_data       = '0;
		sr1_rob_entry  = '0;
		sr2_busy       = 1'b0;
		sr2_data       = '0;
		sr2_rob_entry  = '0;
		dest_busy      = 1'b0;
		dest_data      = '0;
		dest_rob_entry = '0;
		cdb_valid      = 1'b0;
		cdb_tag        = '0;
		cdb_data       = '0;
		rob_full       = 1'b0;
		rob_addr       = '0;
		rob_sr1_value  = '0;
		rob_sr1_valid  = 1'b0;
		rob_sr2_value  = '0;
		rob_sr2_valid  = 1'b0;
		alu_rs_busy    = '0;
		ldstr_full     = 1'b0;
		predict_bit    = 1'b0;
	endtask

	task automatic begin_cycle();
		@(posedge clk);
		#10;  // Drive after the edge
	endtask

	task automatic settle();
		#70;
	endtask

	// Register file, ROB and CDB contents
	task automatic randomize_state();
		logic [31:0] r;
		r = $random(seed);
		sr1_busy       = r[0];
		sr2_busy       = r[1];
		dest_busy      = r[2];
		sr1_rob_entry  = r[5:3];
		sr2_rob_entry  = r[8:6];
		dest_rob_entry = r[11:9];
		rob_addr       = r[14:12];
		rob_sr1_valid  = r[15];
		rob_sr2_valid  = r[16];
		cdb_valid      = r[17];
		case (r[19:18])
			2'd0: cdb_tag = sr1_rob_entry;  // Bias toward forwarding hits
			2'd1: cdb_tag = sr2_rob_entry;
			2'd2: cdb_tag = dest_rob_entry;
			default: cdb_tag = r[22:20];
		endcase
		alu_rs_busy = r[25:23];
		r = $random(seed);
		sr1_data  = r[15:0];
		sr2_data  = r[31:16];
		r = $random(seed);
		dest_data = r[15:0];
		cdb_data  = r[31:16];
		r = $random(seed);
		rob_sr1_value = r[15:0];
		rob_sr2_value = r[31:16];
		r = $random(seed);
		curr_pc = {r[15:1], 1'b0};
	endtask

	task automatic check_no_issue(input logic exp_stall);
		check_eq("stall", exp_stall, stall);
		check_eq("rob_write_enable", 1'b0, rob_write_enable);
		check_eq("ldstr_write_enable", 1'b0, ldstr_write_enable);
		check_eq("ld_reg_busy_dest", 1'b0, ld_reg_busy_dest);
		check_eq("issue_ld_busy_dest", 1'b0, issue_ld_busy_dest);
		check_eq("issue_ld_vj", 1'b0, issue_ld_vj);
		check_eq("issue_ld_vk", 1'b0, issue_ld_vk);
		check_eq("issue_ld_qj", 1'b0, issue_ld_qj);
		check_eq("issue_ld_qk", 1'b0, issue_ld_qk);
		check_eq("pcmux_sel", 1'b0, pcmux_sel);
	endtask

	task automatic run_alu(input int iters);
		logic [31:0] r;
		lc3b_opcode  op;
		logic [2:0]  dr;
		logic        imm;
		logic [4:0]  low;
		logic [19:0] e1;
		logic [19:0] e2;
		test_name = "alu_issue";
		for (int n = 0; n < iters; n++)
		begin
			begin_cycle();
			randomize_state();
			r = $random(seed);
			case (r[1:0])
				2'd0: op = op_add;
				2'd1: op = op_and;
				2'd2: op = op_not;
				default: op = op_shf;
			endcase
			dr  = r[4:2];
			imm = r[5];
			low = r[10:6];
			if (alu_rs_busy == 3'b111)
				alu_rs_busy = {1'b0, r[12:11]};
			ldstr_full   = r[13];  // Must not matter for ALU ops
			rob_full     = 1'b0;
			predict_bit  = 1'b0;
			instr        = {op, dr, r[16:14], imm, low};
			instr_is_new = 1'b1;
			settle();
			e1 = expect_operand(sr1_busy, sr1_data, sr1_rob_entry, rob_sr1_valid, rob_sr1_value);
			e2 = expect_operand(sr2_busy, sr2_data, sr2_rob_entry, rob_sr2_valid, rob_sr2_value);
			check_eq("stall", 1'b0, stall);
			check_eq("rob_write_enable", 1'b1, rob_write_enable);
			check_eq("rob_opcode", op, rob_opcode);
			check_eq("issue_ld_busy_dest", 1'b1, issue_ld_busy_dest);
			check_eq("res_op_in", op, res_op_in);
			check_eq("res_station_id", lowest_free(alu_rs_busy), res_station_id);
			check_eq("issue_ld_vj", e1[19], issue_ld_vj);
			check_eq("issue_ld_qj", !e1[19], issue_ld_qj);
			if (e1[19])
				check_eq("res_vj", e1[15:0], res_vj);
			else
				check_eq("res_qj", e1[18:16], res_qj);
			if (imm || (op == op_shf))
			begin
				check_eq("res_vk", sext(low, 5), res_vk);
				check_eq("issue_ld_vk", 1'b1, issue_ld_vk);
				check_eq("issue_ld_qk", 1'b0, issue_ld_qk);
			end
			else
			begin
				check_eq("issue_ld_vk", e2[19], issue_ld_vk);
				check_eq("issue_ld_qk", !e2[19], issue_ld_qk);
				if (e2[19])
					check_eq("res_vk", e2[15:0], res_vk);
				else
					check_eq("res_qk", e2[18:16], res_qk);
			end
			check_eq("rob_sr2_read_addr", sr2_rob_entry, rob_sr2_read_addr);
			check_eq("res_dest", rob_addr, res_dest);
			check_eq("rob_dest", dr, rob_dest);
			check_eq("reg_dest", dr, reg_dest);
			check_eq("reg_rob_entry", rob_addr, reg_rob_entry);
			check_eq("ld_reg_busy_dest", 1'b1, ld_reg_busy_dest);
			check_eq("ldstr_write_enable", 1'b0, ldstr_write_enable);
		end
	endtask

	task automatic run_backpressure();
		logic [31:0] r;
		for (int c = 0; c < 4; c++)
		begin
			for (int n = 0; n < 3; n++)
			begin
				begin_cycle();
				randomize_state();
				r            = $random(seed);
				rob_full     = 1'b0;
				ldstr_full   = 1'b0;
				predict_bit  = 1'b0;
				instr_is_new = 1'b1;
				alu_rs_busy  = 3'b000;
				case (n)
					0: instr = {op_add, r[15:4]};
					1: instr = {op_ldr, r[15:4]};
					default: instr = {op_ldi, r[15:4]};
				endcase
				case (c)
					0:
					begin
						test_name = "rob_full";
						rob_full  = 1'b1;
					end
					1:
					begin
						test_name   = "stations_full";
						alu_rs_busy = 3'b111;
						instr       = {op_and, r[15:4]};
					end
					2:
					begin
						test_name  = "buffer_full";
						ldstr_full = 1'b1;
						instr      = (n == 0) ? {op_stb, r[15:4]} : instr;
					end
					default:
					begin
						test_name    = "not_new";
						instr_is_new = 1'b0;
					end
				endcase
				settle();
				check_no_issue(c != 3);
			end
		end
	endtask

	task automatic run_mem(input int iters);
		logic [31:0] r;
		lc3b_opcode  op;
		logic [2:0]  dr;
		logic [5:0]  off6;
		logic        is_store;
		logic [19:0] eb;
		logic [19:0] es;
		test_name = "load_store";
		for (int n = 0; n < iters; n++)
		begin
			begin_cycle();
			randomize_state();
			r = $random(seed);
			case (r[1:0])
				2'd0: op = op_ldr;
				2'd1: op = op_ldb;
				2'd2: op = op_str;
				default: op = op_stb;
			endcase
			dr           = r[4:2];
			off6         = r[10:5];
			rob_full     = 1'b0;
			ldstr_full   = 1'b0;
			predict_bit  = 1'b0;
			instr        = {op, dr, r[13:11], off6};
			instr_is_new = 1'b1;
			settle();
			is_store = (op == op_str) || (op == op_stb);
			eb = expect_operand(sr1_busy, sr1_data, sr1_rob_entry, rob_sr1_valid, rob_sr1_value);
			es = expect_operand(dest_busy, dest_data, dest_rob_entry, rob_sr2_valid, rob_sr2_value);
			check_eq("stall", 1'b0, stall);
			check_eq("ldstr_write_enable", 1'b1, ldstr_write_enable);
			check_eq("rob_write_enable", 1'b1, rob_write_enable);
			check_eq("rob_opcode", op, rob_opcode);
			if ((op == op_ldb) || (op == op_stb))
				check_eq("ldstr_offset", sext(off6, 6), ldstr_offset);
			else
				check_eq("ldstr_offset", sext(off6, 6) << 1, ldstr_offset);
			check_eq("ldstr_vbase_valid", eb[19], ldstr_vbase_valid);
			if (eb[19])
				check_eq("ldstr_vbase", eb[15:0], ldstr_vbase);
			else
				check_eq("ldstr_qbase", eb[18:16], ldstr_qbase);
			if (is_store)
			begin
				check_eq("ldstr_vsrc_valid", es[19], ldstr_vsrc_valid);
				if (es[19])
					check_eq("ldstr_vsrc", es[15:0], ldstr_vsrc);
				else
					check_eq("ldstr_qsrc", es[18:16], ldstr_qsrc);
				check_eq("ldstr_dest", 3'd0, ldstr_dest);
				check_eq("rob_dest", 3'd0, rob_dest);
				check_eq("rob_sr2_read_addr", dest_rob_entry, rob_sr2_read_addr);
				check_eq("ld_reg_busy_dest", 1'b0, ld_reg_busy_dest);
			end
			else
			begin
				check_eq("ldstr_dest", rob_addr, ldstr_dest);
				check_eq("rob_dest", dr, rob_dest);
				check_eq("reg_dest", dr, reg_dest);
				check_eq("ld_reg_busy_dest", 1'b1, ld_reg_busy_dest);
				check_eq("reg_rob_entry", rob_addr, reg_rob_entry);
			end
		end
	endtask

	task automatic run_branch();
		logic [31:0] r;
		lc3b_word    target;
		for (int n = 0; n < 2; n++)
		begin
			for (int taken = 0; taken < 2; taken++)
			begin
				test_name = taken ? "br_taken" : "br_not_taken";
				begin_cycle();
				randomize_state();
				r            = $random(seed);
				rob_full     = 1'b0;
				predict_bit  = taken;
				instr        = {op_br, r[11:9], r[8:0]};
				instr_is_new = 1'b1;
				settle();
				target = curr_pc + (sext(r[8:0], 9) << 1);
				check_eq("br_pc", target, br_pc);
				check_eq("pcmux_sel", taken, pcmux_sel);
				check_eq("stall", 1'b0, stall);
				check_eq("rob_write_enable", 1'b1, rob_write_enable);
				check_eq("rob_value_in", taken ? curr_pc : target, rob_value_in);
			end
			// Stale word right after the redirect
			test_name = "br_shadow";
			begin_cycle();
			predict_bit = 1'b0;
			alu_rs_busy = 3'b000;
			instr       = {op_add, r[15:4]};
			settle();
			check_no_issue(1'b0);
			test_name = "after_shadow";
			begin_cycle();
			settle();
			check_eq("stall", 1'b0, stall);
			check_eq("rob_write_enable", 1'b1, rob_write_enable);
			test_name = "lea";
			begin_cycle();
			randomize_state();
			r     = $random(seed);
			instr = {op_lea, r[11:9], r[8:0]};
			settle();
			check_eq("rob_value_in", curr_pc + (sext(r[8:0], 9) << 1), rob_value_in);
			check_eq("rob_write_enable", 1'b1, rob_write_enable);
			check_eq("reg_dest", r[11:9], reg_dest);
			check_eq("ld_reg_busy_dest", 1'b1, ld_reg_busy_dest);
			check_eq("reg_rob_entry", rob_addr, reg_rob_entry);
		end
	endtask

	task automatic run_ldi();
		logic [31:0]  r;
		lc3b_rob_addr first_rob;
		logic [19:0]  eb;
		for (int p = 0; p < 2; p++)
		begin
			test_name = "ldi_first";
			begin_cycle();
			randomize_state();
			r            = $random(seed);
			rob_full     = 1'b0;
			ldstr_full   = 1'b0;
			predict_bit  = 1'b0;
			instr        = {op_ldi, r[11:9], r[8:6], r[5:0]};
			instr_is_new = 1'b1;
			first_rob    = rob_addr;
			settle();
			eb = expect_operand(sr1_busy, sr1_data, sr1_rob_entry, rob_sr1_valid, rob_sr1_value);
			check_eq("stall", 1'b1, stall);
			check_eq("ldstr_write_enable", 1'b1, ldstr_write_enable);
			check_eq("rob_write_enable", 1'b1, rob_write_enable);
			check_eq("ldstr_offset", 16'h0000, ldstr_offset);
			check_eq("ldstr_dest", first_rob, ldstr_dest);
			check_eq("ldstr_vbase_valid", eb[19], ldstr_vbase_valid);
			if (eb[19])
				check_eq("ldstr_vbase", eb[15:0], ldstr_vbase);
			else
				check_eq("ldstr_qbase", eb[18:16], ldstr_qbase);
			check_eq("ld_reg_busy_dest", 1'b0, ld_reg_busy_dest);

			// Same word again, now the dependent load
			test_name = p ? "ldi_second_cdb" : "ldi_second_wait";
			begin_cycle();
			randomize_state();
			rob_addr  = first_rob + 3'd1;
			cdb_valid = p ? 1'b1 : cdb_valid;
			cdb_tag   = p ? first_rob : (first_rob ^ 3'b100);
			settle();
			check_eq("stall", 1'b0, stall);
			check_eq("ldstr_write_enable", 1'b1, ldstr_write_enable);
			check_eq("ldstr_offset", sext(r[5:0], 6) << 1, ldstr_offset);
			check_eq("ldstr_dest", rob_addr, ldstr_dest);
			check_eq("ldstr_vbase_valid", p, ldstr_vbase_valid);
			if (p)
				check_eq("ldstr_vbase", cdb_data, ldstr_vbase);
			else
				check_eq("ldstr_qbase", first_rob, ldstr_qbase);
			check_eq("reg_dest", r[11:9], reg_dest);
			check_eq("ld_reg_busy_dest", 1'b1, ld_reg_busy_dest);
			check_eq("reg_rob_entry", rob_addr, reg_rob_entry);
		end
	endtask

	initial
	begin
		set_idle();
		arst_n = 1'b0;
		repeat (5) @(posedge clk);
		#10;
		arst_n = 1'b1;
		run_alu(alu_iters);
		run_backpressure();
		run_mem(mem_iters);
		run_branch();
		run_ldi();
		begin_cycle();
		set_idle();
		$display("Simulation finished: PASS");
		$finish;
	end

	// Watchdog sized from the test lengths
	initial
	begin
		#((test_cycles + 20) * 100);
		$display("Timeout: tests did not finish within %0d cycles", test_cycles + 20);
		fail_stop();
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+common
common/lc3b_pkg.sv
rtl/operand_resolve.sv
issue/issue_decode.sv
issue/issue_sequencer.sv
issue/issue_control.sv
tb/tb_issue_control.sv

// File: Bender.yml
package:
  name: lc3b_issue

sources:
  - include_dirs:
      - common
    files:
      - common/lc3b_pkg.sv
      - rtl/operand_resolve.sv
      - issue/issue_decode.sv
      - issue/issue_sequencer.sv
      - issue/issue_control.sv
      - target: test
        files:
          - tb/tb_issue_control.sv
